//--- build.f
+incdir+test
src/imuldiv_pkg.sv
src/imuldiv_if.sv
src/imuldiv_mul_iterative.sv
src/imuldiv_div_iterative.sv
src/imuldiv_dispatch.sv
src/imuldiv_top.sv
test/imuldiv_tb.sv

//--- Makefile
# Verilator build and run for the multiply/divide unit

VERILATOR ?= verilator
TOP       ?= imuldiv_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator exit status is the test result
test: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

//--- test/imuldiv_tests.svh
//------------------------------
// directed tests and reference model
//------------------------------

// expected result from the op rules with the division special cases guarded
function automatic logic [63:0] ref_result(input muldiv_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  logic signed [63:0] sa64;
  logic signed [63:0] sb64;
  logic        [31:0] word;
  logic        [63:0] res;
  logic               ovf;
  sa   = a;
  sb   = b;
  sa64 = sa;
  sb64 = sb;
  ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
  word = '0;
  res  = '0;
  case (op)
    OP_MUL:  res = sa64 * sb64;
    OP_MULU: res = {32'd0, a} * {32'd0, b};
    OP_DIV: begin
      // signed operands stay alone so the division is done signed
      if (b == 0) begin
        word = 32'hffff_ffff;
      end else if (ovf) begin
        word = a;
      end else begin
        word = sa / sb;
      end
      res = {{32{word[31]}}, word};
    end
    OP_REM: begin
      if (b == 0) begin
        word = a;
      end else if (ovf) begin
        word = 32'd0;
      end else begin
        word = sa % sb;
      end
      res = {{32{word[31]}}, word};
    end
    OP_DIVU: res = {32'd0, (b == 0) ? 32'hffff_ffff : a / b};
    OP_REMU: res = {32'd0, (b == 0) ? a : a % b};
    default: res = '0;
  endcase
  return res;
endfunction

task automatic issue_and_expect(input string name, input muldiv_op_e op,
                                input logic [31:0] a, input logic [31:0] b,
                                input logic [63:0] expected);
  logic [63:0] got;
  send_req(op, a, b);
  recv_resp(got);
  check(name, expected, got);
endtask

task automatic issue_and_compare(input string name, input muldiv_op_e op,
                                 input logic [31:0] a, input logic [31:0] b);
  issue_and_expect(name, op, a, b, ref_result(op, a, b));
endtask

// every op against all four sign mixes plus two wide operand pairs
task automatic fixed_operand_ops();
  muldiv_op_e  ops [6];
  logic [31:0] a_vals [6];
  logic [31:0] b_vals [6];
  ops    = '{OP_MUL, OP_MULU, OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  a_vals = '{32'h0000_03e8, 32'hffff_fc18, 32'h0000_03e8, 32'hffff_fc18,
             32'h7fff_ffff, 32'h8000_0001};
  b_vals = '{32'h0000_0025, 32'h0000_0025, 32'hffff_ffdb, 32'hffff_ffdb,
             32'h7fff_fffe, 32'h0001_0003};
  for (int i = 0; i < 6; i++) begin
    for (int j = 0; j < 6; j++) begin
      issue_and_compare($sformatf("fixed %s pair %0d", ops[i].name(), j),
                        ops[i], a_vals[j], b_vals[j]);
    end
  end
endtask

// expected values written out from the special-case rules
task automatic divide_special_cases();
  muldiv_op_e  ops [4];
  logic [63:0] zero_exp [4];
  logic [63:0] ovf_exp [4];
  ops      = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  zero_exp = '{64'hffff_ffff_ffff_ffff, 64'h0000_0000_ffff_ffff,
               64'hffff_ffff_dead_beef, 64'h0000_0000_dead_beef};
  // unsigned ops see 0x80000000 / 0xffffffff as an ordinary division
  ovf_exp  = '{64'hffff_ffff_8000_0000, 64'h0000_0000_0000_0000,
               64'h0000_0000_0000_0000, 64'h0000_0000_8000_0000};
  for (int i = 0; i < 4; i++) begin
    issue_and_expect($sformatf("%s by zero", ops[i].name()), ops[i],
                     32'hdead_beef, 32'h0000_0000, zero_exp[i]);
    issue_and_expect($sformatf("%s min by -1", ops[i].name()), ops[i],
                     32'h8000_0000, 32'hffff_ffff, ovf_exp[i]);
  end
endtask

task automatic random_request_batch();
  logic [31:0] pick;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] sh;
  muldiv_op_e  op;
  for (int i = 0; i < 40; i++) begin
    rand_bits(3, pick);
    op = muldiv_op_e'(3'(pick % 6));
    rand_bits(32, a);
    rand_bits(32, b);
    // shorter divisors give quotients of every size
    rand_bits(5, sh);
    b = b >> sh[4:0];
    issue_and_compare($sformatf("random %0d %s", i, op.name()), op, a, b);
  end
endtask

task automatic mul_div_back_to_back();
  logic [63:0] first;
  logic [63:0] second;
  int unsigned first_cycle;
  send_req(OP_MUL, 32'hfedc_ba98, 32'h0000_1234);
  first_cycle = accept_cycle;
  send_req(OP_DIV, 32'h8765_4321, 32'h0000_0017);
  check("mul then div accept gap", 64'd1, 64'(accept_cycle - first_cycle));
  recv_resp(first);
  recv_resp(second);
  check("mul then div first", ref_result(OP_MUL, 32'hfedc_ba98, 32'h0000_1234), first);
  check("mul then div second", ref_result(OP_DIV, 32'h8765_4321, 32'h0000_0017), second);
  // reverse order with the divider first
  send_req(OP_REMU, 32'hc001_d00d, 32'h0000_0301);
  first_cycle = accept_cycle;
  send_req(OP_MULU, 32'hffff_ffff, 32'h8000_0003);
  check("div then mul accept gap", 64'd1, 64'(accept_cycle - first_cycle));
  recv_resp(first);
  recv_resp(second);
  check("div then mul first", ref_result(OP_REMU, 32'hc001_d00d, 32'h0000_0301), first);
  check("div then mul second", ref_result(OP_MULU, 32'hffff_ffff, 32'h8000_0003), second);
endtask

task automatic stalled_responses();
  logic [63:0] first;
  logic [63:0] second;
  send_req(OP_DIV, 32'h9abc_def0, 32'hffff_fff3);
  send_req(OP_MUL, 32'h8000_0000, 32'h7fff_ffff);
  // resp_rdy stays low while both units finish and hold their results
  repeat (100) @(negedge clk);
  req_op = OP_MULU;
  #1;
  check("stall blocks mul", 64'd0, {63'd0, req_rdy});
  @(negedge clk);
  req_op = OP_REM;
  #1;
  check("stall blocks div", 64'd0, {63'd0, req_rdy});
  check("stall holds response", 64'd1, {63'd0, resp_val});
  @(negedge clk);
  recv_resp(first);
  recv_resp(second);
  check("stall first", ref_result(OP_DIV, 32'h9abc_def0, 32'hffff_fff3), first);
  check("stall second", ref_result(OP_MUL, 32'h8000_0000, 32'h7fff_ffff), second);
  // unit must be usable again once drained
  issue_and_compare("after stall", OP_DIVU, 32'hffff_fff0, 32'h0000_0007);
endtask

//--- test/imuldiv_tb.sv
//------------------------------
// multiply/divide unit testbench
// drives imuldiv_top through directed and random requests
//------------------------------

module imuldiv_tb import imuldiv_pkg::*; ();

  // cycles any single wait may take before the run is abandoned
  localparam int wait_limit = 200;

  logic            clk;
  logic            reset;
  muldiv_op_e      req_op;
  logic [xlen-1:0] req_a;
  logic [xlen-1:0] req_b;
  logic            req_val;
  logic            req_rdy;
  logic [rlen-1:0] resp_result;
  logic            resp_val;
  logic            resp_rdy;

  // random source and cycle bookkeeping
  logic [31:0]     lfsr_state;
  int unsigned     cycle_cnt;
  int unsigned     accept_cycle;

  imuldiv_top uut (
    .clk         (clk),
    .reset       (reset),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //------------------------------
  // helpers
  //------------------------------

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit with new bits entering at the lsb
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic abort_run(input string reason);
    $display("Test FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      abort_run("a response did not match its expected value");
    end
  endtask

  // called on a falling edge and returns on the falling edge after the transfer
  task automatic send_req(input muldiv_op_e op, input logic [31:0] a,
                          input logic [31:0] b);
    int waited;
    waited = 0;
    req_op  = op;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    // rdy settles well before the next rising edge
    #1;
    while (!req_rdy) begin
      if (waited == wait_limit) begin
        abort_run("the DUT never accepted a request");
      end
      waited++;
      @(negedge clk);
      #1;
    end
    @(posedge clk);
    @(negedge clk);
    accept_cycle = cycle_cnt;
    req_val = 1'b0;
  endtask

  // same edge alignment as send_req
  task automatic recv_resp(output logic [63:0] result);
    int waited;
    waited = 0;
    resp_rdy = 1'b1;
    #1;
    while (!resp_val) begin
      if (waited == wait_limit) begin
        abort_run("no response arrived from the DUT");
      end
      waited++;
      @(negedge clk);
      #1;
    end
    result = resp_result;
    @(posedge clk);
    @(negedge clk);
    resp_rdy = 1'b0;
  endtask

  `include "imuldiv_tests.svh"

  //------------------------------
  // test sequence
  //------------------------------

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    req_op       = OP_MUL;
    req_a        = '0;
    req_b        = '0;
    req_val      = 1'b0;
    resp_rdy     = 1'b0;
    lfsr_state   = 32'h9c069f3d;
    cycle_cnt    = 0;
    accept_cycle = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // nothing may be offered before any request
    check("resp_val after reset", 64'd0, {63'd0, resp_val});
    fixed_operand_ops();
    divide_special_cases();
    random_request_batch();
    mul_div_back_to_back();
    stalled_responses();
    $display("Test OK");
    $finish;
  end

endmodule

//--- src/imuldiv_top.sv
//------------------------------
// multiply/divide unit top level
//------------------------------

module imuldiv_top import imuldiv_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  // request side
  input  muldiv_op_e      req_op,
  input  logic [xlen-1:0] req_a,
  input  logic [xlen-1:0] req_b,
  input  logic            req_val,
  output logic            req_rdy,
  // response side
  output logic [rlen-1:0] resp_result,
  output logic            resp_val,
  input  logic            resp_rdy
);

  // one request and one response channel per unit
  muldiv_req_if  mul_req ();
  muldiv_req_if  div_req ();
  muldiv_resp_if mul_resp ();
  muldiv_resp_if div_resp ();

  imuldiv_dispatch u_dispatch (
    .clk         (clk),
    .reset       (reset),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .mul_req     (mul_req.issuer),
    .div_req     (div_req.issuer),
    .mul_resp    (mul_resp.collector),
    .div_resp    (div_resp.collector)
  );

  imuldiv_mul_iterative u_mul (
    .clk   (clk),
    .reset (reset),
    .req   (mul_req.unit),
    .resp  (mul_resp.unit)
  );

  imuldiv_div_iterative u_div (
    .clk   (clk),
    .reset (reset),
    .req   (div_req.unit),
    .resp  (div_resp.unit)
  );

endmodule

//--- src/imuldiv_dispatch.sv
//------------------------------
// request dispatcher
// routes by opcode, returns results in request order
//------------------------------

module imuldiv_dispatch import imuldiv_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  muldiv_op_e            req_op,
  input  logic [xlen-1:0]       req_a,
  input  logic [xlen-1:0]       req_b,
  input  logic                  req_val,
  output logic                  req_rdy,
  output logic [rlen-1:0]       resp_result,
  output logic                  resp_val,
  input  logic                  resp_rdy,
  muldiv_req_if.issuer          mul_req,
  muldiv_req_if.issuer          div_req,
  muldiv_resp_if.collector      mul_resp,
  muldiv_resp_if.collector      div_resp
);

  // order queue of unit ids where 1 means the divider
  logic [order_depth-1:0]             order_q;
  logic [$clog2(order_depth)-1:0]     wr_ptr;
  logic [$clog2(order_depth)-1:0]     rd_ptr;
  logic [$clog2(order_depth+1)-1:0]   q_count;

  logic req_is_div;
  logic q_full;
  logic q_empty;
  logic head_is_div;
  logic push;
  logic pop;

  assign req_is_div  = req_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  assign q_full      = (q_count == order_depth);
  assign q_empty     = (q_count == 0);
  assign head_is_div = order_q[rd_ptr];

  //------------------------------
  // request side
  //------------------------------

  // rdy looks only at the selected unit and the queue
  assign req_rdy = !q_full && (req_is_div ? div_req.rdy : mul_req.rdy);
  assign push    = req_val && req_rdy;

  assign mul_req.op  = req_op;
  assign mul_req.a   = req_a;
  assign mul_req.b   = req_b;
  assign mul_req.val = req_val && !req_is_div && !q_full;
  assign div_req.op  = req_op;
  assign div_req.a   = req_a;
  assign div_req.b   = req_b;
  assign div_req.val = req_val && req_is_div && !q_full;

  //------------------------------
  // response side
  //------------------------------

  // only the head unit may hand off while the other waits in ST_DONE
  assign resp_val     = !q_empty && (head_is_div ? div_resp.val : mul_resp.val);
  assign resp_result  = head_is_div ? div_resp.result : mul_resp.result;
  assign mul_resp.rdy = resp_rdy && !q_empty && !head_is_div;
  assign div_resp.rdy = resp_rdy && !q_empty && head_is_div;
  assign pop          = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (push) begin
      order_q[wr_ptr] <= req_is_div;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == order_depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == order_depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop in one edge leave the count alone
      if (push && !pop) begin
        q_count <= q_count + 1'b1;
      end else if (pop && !push) begin
        q_count <= q_count - 1'b1;
      end
    end
  end

  // the count never wraps past either end of the queue
  a_q_no_overflow: assert property (@(posedge clk) disable iff (reset)
    q_count <= order_depth);

  // a drained queue leaves no unit working on a lost entry
  a_q_no_underflow: assert property (@(posedge clk) disable iff (reset)
    q_empty |-> (mul_req.rdy && div_req.rdy));

  // a finished unit always has its id waiting in the queue
  a_no_orphan_resp: assert property (@(posedge clk) disable iff (reset)
    (mul_resp.val || div_resp.val) |-> !q_empty);

endmodule

//--- src/imuldiv_div_iterative.sv
//------------------------------
// iterative divider
// restoring, 32 steps, quotient or remainder
//------------------------------

module imuldiv_div_iterative import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  muldiv_req_if.unit  req,
  muldiv_resp_if.unit resp
);

  // control state
  unit_state_e      state;
  logic [cnt_w-1:0] step_cnt;

  // {remainder, quotient} pair, quotient bits shift in from the right
  logic [rlen-1:0] pair_reg;
  logic [xlen-1:0] dvsr_reg;
  logic [rlen-1:0] res_reg;
  // op flags and signs taken at accept
  logic            is_rem_reg;
  logic            is_signed_reg;
  logic            neg_q_reg;
  logic            neg_r_reg;
  logic            div_zero_reg;
  logic            ovf_reg;

  logic            req_fire;
  logic            resp_fire;
  logic            op_signed;
  logic            op_rem;
  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;
  logic            last_step;
  logic [xlen:0]   trial_hi;
  logic [xlen:0]   trial_diff;
  logic [xlen-1:0] quo_fix;
  logic [xlen-1:0] rem_fix;
  logic [xlen-1:0] pick;
  logic [rlen-1:0] res_next;

  assign req_fire  = req.val && req.rdy;
  assign resp_fire = resp.val && resp.rdy;
  assign op_signed = (req.op == OP_DIV) || (req.op == OP_REM);
  assign op_rem    = (req.op == OP_REM) || (req.op == OP_REMU);
  assign a_mag     = (op_signed && req.a[xlen-1]) ? -req.a : req.a;
  assign b_mag     = (op_signed && req.b[xlen-1]) ? -req.b : req.b;
  assign last_step = (step_cnt == cnt_w'(step_count - 1));

  // upper half after the left shift, one extra bit to see the borrow
  assign trial_hi   = pair_reg[rlen-1:xlen-1];
  assign trial_diff = trial_hi - {1'b0, dvsr_reg};

  //------------------------------
  // control FSM
  //------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_fire) begin
            state    <= ST_CALC;
            step_cnt <= '0;
          end
        end
        ST_CALC: begin
          if (last_step) begin
            state <= ST_FIX;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        ST_FIX: begin
          state <= ST_DONE;
        end
        ST_DONE: begin
          if (resp_fire) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //------------------------------
  // sign fix and special cases
  //------------------------------

  always_comb begin
    quo_fix = neg_q_reg ? -pair_reg[xlen-1:0] : pair_reg[xlen-1:0];
    // remainder follows the dividend, so x / 0 leaves rem = x
    rem_fix = neg_r_reg ? -pair_reg[rlen-1:xlen] : pair_reg[rlen-1:xlen];
    if (div_zero_reg) begin
      quo_fix = '1;
    end
    // most negative / -1 wraps back to the dividend
    if (ovf_reg) begin
      quo_fix = {1'b1, {(xlen-1){1'b0}}};
      rem_fix = '0;
    end
    pick = is_rem_reg ? rem_fix : quo_fix;
    if (is_signed_reg) begin
      res_next = {{(rlen-xlen){pick[xlen-1]}}, pick};
    end else begin
      res_next = {{(rlen-xlen){1'b0}}, pick};
    end
  end

  //------------------------------
  // datapath
  //------------------------------

  always_ff @(posedge clk) begin
    case (state)
      ST_IDLE: begin
        if (req_fire) begin
          pair_reg      <= {{(rlen-xlen){1'b0}}, a_mag};
          dvsr_reg      <= b_mag;
          is_rem_reg    <= op_rem;
          is_signed_reg <= op_signed;
          neg_q_reg     <= op_signed && (req.a[xlen-1] ^ req.b[xlen-1]);
          neg_r_reg     <= op_signed && req.a[xlen-1];
          div_zero_reg  <= (req.b == '0);
          ovf_reg       <= op_signed && (req.a == {1'b1, {(xlen-1){1'b0}}}) && (req.b == '1);
        end
      end
      ST_CALC: begin
        // keep the subtraction only when it did not borrow
        if (!trial_diff[xlen]) begin
          pair_reg <= {trial_diff[xlen-1:0], pair_reg[xlen-2:0], 1'b1};
        end else begin
          pair_reg <= {pair_reg[rlen-2:0], 1'b0};
        end
      end
      ST_FIX: begin
        res_reg <= res_next;
      end
      default: begin
      end
    endcase
  end

  assign req.rdy     = (state == ST_IDLE);
  assign resp.val    = (state == ST_DONE);
  assign resp.result = res_reg;

  // after 32 steps the partial remainder is reduced below the divisor
  a_div_rem_range: assert property (@(posedge clk) disable iff (reset)
    (state == ST_FIX && dvsr_reg != '0) |-> pair_reg[rlen-1:xlen] < dvsr_reg);

endmodule

//--- src/imuldiv_mul_iterative.sv
//------------------------------
// iterative multiplier
// shift-add over 32 steps, sign fix at the end
//------------------------------

module imuldiv_mul_iterative import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  muldiv_req_if.unit  req,
  muldiv_resp_if.unit resp
);

  // control state
  unit_state_e      state;
  logic [cnt_w-1:0] step_cnt;

  // datapath registers
  logic [rlen-1:0] a_reg;
  logic [xlen-1:0] b_reg;
  logic [rlen-1:0] acc_reg;
  // product must be negated in ST_FIX
  logic            neg_reg;

  logic            req_fire;
  logic            resp_fire;
  logic            op_signed;
  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;
  logic            last_step;

  assign req_fire  = req.val && req.rdy;
  assign resp_fire = resp.val && resp.rdy;

  // MULU takes the operands as they are
  assign op_signed = (req.op == OP_MUL);
  assign a_mag     = (op_signed && req.a[xlen-1]) ? -req.a : req.a;
  assign b_mag     = (op_signed && req.b[xlen-1]) ? -req.b : req.b;
  assign last_step = (step_cnt == cnt_w'(step_count - 1));

  //------------------------------
  // control FSM
  //------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_fire) begin
            state    <= ST_CALC;
            step_cnt <= '0;
          end
        end
        ST_CALC: begin
          // 32 steps, then one cycle of sign fix
          if (last_step) begin
            state <= ST_FIX;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        ST_FIX: begin
          state <= ST_DONE;
        end
        ST_DONE: begin
          // hold the product until the dispatcher takes it
          if (resp_fire) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //------------------------------
  // datapath
  //------------------------------

  always_ff @(posedge clk) begin
    case (state)
      ST_IDLE: begin
        if (req_fire) begin
          // a sits in the low half and moves up one place per step
          a_reg   <= {{(rlen-xlen){1'b0}}, a_mag};
          b_reg   <= b_mag;
          acc_reg <= '0;
          neg_reg <= op_signed && (req.a[xlen-1] ^ req.b[xlen-1]);
        end
      end
      ST_CALC: begin
        // add shifted a for each set bit of b, lsb first
        if (b_reg[0]) begin
          acc_reg <= acc_reg + a_reg;
        end
        a_reg <= a_reg << 1;
        b_reg <= b_reg >> 1;
      end
      ST_FIX: begin
        if (neg_reg) begin
          acc_reg <= -acc_reg;
        end
      end
      default: begin
      end
    endcase
  end

  assign req.rdy     = (state == ST_IDLE);
  assign resp.val    = (state == ST_DONE);
  assign resp.result = acc_reg;

  // product is offered exactly 34 cycles after the accepting edge
  a_mul_latency: assert property (@(posedge clk) disable iff (reset)
    req_fire |-> ##34 resp.val);

  // val only ever rises out of the sign fix cycle
  a_mul_val_done: assert property (@(posedge clk) disable iff (reset)
    $rose(resp.val) |-> $past(state) == ST_FIX);

  a_mul_cnt_range: assert property (@(posedge clk) disable iff (reset)
    step_cnt <= cnt_w'(step_count - 1));

endmodule

//--- src/imuldiv_if.sv
//------------------------------
// request and response interfaces
// valid/ready channels between dispatcher and units
//------------------------------

// request channel toward one unit
interface muldiv_req_if import imuldiv_pkg::*; ();

  muldiv_op_e      op;
  logic [xlen-1:0] a;
  logic [xlen-1:0] b;
  logic            val;
  logic            rdy;

  // dispatcher side
  modport issuer (
    output op, a, b, val,
    input  rdy
  );

  // unit side, rdy comes from the unit FSM
  modport unit (
    input  op, a, b, val,
    output rdy
  );

endinterface

// response channel back from one unit
interface muldiv_resp_if import imuldiv_pkg::*; ();

  logic [rlen-1:0] result;
  logic            val;
  logic            rdy;

  // unit side, result held while val is high
  modport unit (
    output result, val,
    input  rdy
  );

  // dispatcher side
  modport collector (
    input  result, val,
    output rdy
  );

endinterface

//--- src/imuldiv_pkg.sv
//------------------------------
// multiply/divide unit package
// widths, opcodes and unit states
//------------------------------

package imuldiv_pkg;

  //------------------------------
  // widths
  //------------------------------

  // operand and result width
  localparam int xlen = 32;
  localparam int rlen = 64;

  // one step per operand bit
  localparam int step_count = xlen;
  // wide enough for step_count - 1
  localparam int cnt_w = 6;

  // one slot per unit, so a mul and a div can both be in flight
  localparam int order_depth = 2;

  //------------------------------
  // enums
  //------------------------------

  // request opcode, 3 bits on the bus
  typedef enum logic [2:0] {
    OP_MUL  = 3'd0,
    OP_MULU = 3'd1,
    OP_DIV  = 3'd2,
    OP_DIVU = 3'd3,
    OP_REM  = 3'd4,
    OP_REMU = 3'd5
  } muldiv_op_e;

  // shared by the multiplier and the divider
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_FIX  = 2'd2,
    ST_DONE = 2'd3
  } unit_state_e;

endpackage
